// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exu
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = tests failed
PASS_MSG  = all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)

.PHONY: all run check clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)
	@echo "simulation log is clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module alu_core (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire logic                 alu_valid,
    input  wire alu_op_pkg::alu_op_t  alu_op,
    input  wire exu_data_pkg::xlen_t  alu_a,
    input  wire exu_data_pkg::xlen_t  alu_b,
    input  wire logic                 alu_word,
    output exu_data_pkg::xlen_t       alu_res,
    output logic                      alu_res_valid
);
    import alu_op_pkg::*;
    import exu_data_pkg::*;

    localparam xlen_t XLEN_MIN = {1'b1, {(`EXU_XLEN-1){1'b0}}};

    shamt_t      shamt;
    logic        lt_s;
    logic        lt_u;
    logic        eq;
    logic        div_zero;
    logic        div_ovf;
    xlen_t       div_b;
    xlen_t       divu_b;
    logic [31:0] sra_word;
    xlen_t       result;

    assign shamt = alu_b[$bits(shamt_t)-1:0];

    assign lt_s = $signed(alu_a) < $signed(alu_b);
    assign lt_u = alu_a < alu_b;
    assign eq   = alu_a == alu_b;

    // corner cases of the divider, resolved without dividing
    assign div_zero = (alu_b == '0);
    assign div_ovf  = (alu_a == XLEN_MIN) && (alu_b == '1);
    assign div_b    = (div_zero || div_ovf) ? xlen_t'(1) : alu_b;

    // unsigned divide has no overflow case
    assign divu_b   = div_zero ? xlen_t'(1) : alu_b;

    assign sra_word = $signed(alu_a[31:0]) >>> shamt;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = alu_a + alu_b;
            ALU_SUB:    result = alu_a - alu_b;
            ALU_PASS_A: result = alu_a;
            ALU_PASS_B: result = alu_b;
            ALU_XOR:    result = alu_a ^ alu_b;
            ALU_OR:     result = alu_a | alu_b;
            ALU_AND:    result = alu_a & alu_b;
            ALU_SLL:    result = alu_a << shamt;
            ALU_SRL:    result = alu_a >> shamt;
            ALU_SLT:    result = xlen_t'(lt_s);
            ALU_SLTU:   result = xlen_t'(lt_u);
            ALU_EQ:     result = xlen_t'(eq);
            ALU_GE:     result = xlen_t'(!lt_s);
            ALU_GEU:    result = xlen_t'(!lt_u);
            ALU_DIV: begin
                if (div_zero) begin
                    result = '1;
                end else if (div_ovf) begin
                    result = alu_a;
                end else begin
                    result = xlen_t'($signed(alu_a) / $signed(div_b));
                end
            end
            ALU_DIVU:   result = div_zero ? '1 : alu_a / divu_b;
            ALU_REM: begin
                if (div_zero) begin
                    result = alu_a;
                end else if (div_ovf) begin
                    result = '0;
                end else begin
                    result = xlen_t'($signed(alu_a) % $signed(div_b));
                end
            end
            ALU_REMU:   result = div_zero ? alu_a : alu_a % divu_b;
            // word form shifts the low half, upper half stays zero
            ALU_SRA:    result = alu_word ? {{(`EXU_XLEN-32){1'b0}}, sra_word}
                                          : xlen_t'($signed(alu_a) >>> shamt);
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_res_valid <= 1'b0;
        end else begin
            alu_res_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            alu_res <= result;
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_op_pkg.sv ====
`default_nettype none

`include "exu_params.svh"

package alu_op_pkg;

    // operation code carried from decode into the execute unit
    typedef logic [4:0] alu_op_t;

    // arithmetic and pass-through
    localparam alu_op_t ALU_ADD    = 5'd0;
    localparam alu_op_t ALU_SUB    = 5'd1;
    localparam alu_op_t ALU_PASS_A = 5'd2;
    localparam alu_op_t ALU_PASS_B = 5'd3;

    // bitwise logic
    localparam alu_op_t ALU_XOR    = 5'd4;
    localparam alu_op_t ALU_OR     = 5'd5;
    localparam alu_op_t ALU_AND    = 5'd6;

    // logical shifts
    localparam alu_op_t ALU_SLL    = 5'd7;
    localparam alu_op_t ALU_SRL    = 5'd8;

    // compares, result is 1 or 0
    localparam alu_op_t ALU_SLT    = 5'd9;
    localparam alu_op_t ALU_SLTU   = 5'd10;
    localparam alu_op_t ALU_EQ     = 5'd11;
    localparam alu_op_t ALU_GE     = 5'd12;
    localparam alu_op_t ALU_GEU    = 5'd13;

    // divide and remainder
    localparam alu_op_t ALU_DIV    = 5'd14;
    localparam alu_op_t ALU_DIVU   = 5'd15;
    localparam alu_op_t ALU_REM    = 5'd16;
    localparam alu_op_t ALU_REMU   = 5'd17;

    // arithmetic shift, word mode aware
    localparam alu_op_t ALU_SRA    = 5'd18;

    // goes through the multiply pipeline instead of the alu core
    localparam alu_op_t ALU_MUL    = 5'd19;

endpackage

`default_nettype wire

// ==== design/exu_data_pkg.sv ====
`default_nettype none

`include "exu_params.svh"

package exu_data_pkg;

    // one datapath word
    typedef logic [`EXU_XLEN-1:0] xlen_t;

    // shift amount, low bits of operand b
    typedef logic [$clog2(`EXU_XLEN)-1:0] shamt_t;

    // operand source select
    typedef logic [1:0] src_sel_t;

    localparam src_sel_t SEL_A_RS1 = 2'd1;
    localparam src_sel_t SEL_B_RS2 = 2'd1;
    localparam src_sel_t SEL_B_CSR = 2'd2;

    // multiplies in flight, issue register plus every stage
    typedef logic [$clog2(`EXU_MUL_STAGES + 2)-1:0] mul_cnt_t;

    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_MUL,
        ISSUE_DRAIN
    } issue_state_t;

endpackage

`default_nettype wire

// ==== design/exu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module exu_issue (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire alu_op_pkg::alu_op_t     op,
    input  wire exu_data_pkg::xlen_t     pc,
    input  wire exu_data_pkg::xlen_t     rs1,
    input  wire exu_data_pkg::xlen_t     rs2,
    input  wire exu_data_pkg::xlen_t     csr,
    input  wire exu_data_pkg::xlen_t     imm,
    input  wire exu_data_pkg::src_sel_t  sel_a,
    input  wire exu_data_pkg::src_sel_t  sel_b,
    input  wire logic                    word_mode,
    output logic                         alu_valid,
    output alu_op_pkg::alu_op_t          alu_op,
    output exu_data_pkg::xlen_t          alu_a,
    output exu_data_pkg::xlen_t          alu_b,
    output logic                         alu_word,
    output logic                         mul_valid,
    output exu_data_pkg::xlen_t          mul_a,
    output exu_data_pkg::xlen_t          mul_b,
    output exu_data_pkg::xlen_t          mul_acc,
    input  wire logic                    mul_done
);
    import alu_op_pkg::*;
    import exu_data_pkg::*;

    issue_state_t state;
    issue_state_t state_next;
    mul_cnt_t     mul_cnt;
    mul_cnt_t     mul_cnt_next;
    xlen_t        rs1_ext;
    xlen_t        a_sel;
    xlen_t        b_sel;
    logic         is_mul;
    logic         accept;
    logic         mul_issue;

    // word mode keeps only the low half of rs1
    assign rs1_ext = word_mode ? {{(`EXU_XLEN-32){1'b0}}, rs1[31:0]} : rs1;
    assign a_sel   = (sel_a == SEL_A_RS1) ? rs1_ext : pc;

    always_comb begin
        case (sel_b)
            SEL_B_RS2: b_sel = rs2;
            SEL_B_CSR: b_sel = csr;
            default:   b_sel = imm;
        endcase
    end

    assign is_mul = (op == ALU_MUL);

    // a non-multiply op waits behind any multiply still in flight
    always_comb begin
        case (state)
            ISSUE_IDLE: in_ready = 1'b1;
            ISSUE_MUL:  in_ready = !(in_valid && !is_mul);
            default:    in_ready = 1'b0;
        endcase
    end

    assign accept    = in_valid && in_ready && !flush;
    assign mul_issue = accept && is_mul;

    assign mul_cnt_next = mul_cnt + mul_cnt_t'(mul_issue) - mul_cnt_t'(mul_done);

    always_comb begin
        state_next = state;
        case (state)
            ISSUE_IDLE: begin
                if (mul_issue) begin
                    state_next = ISSUE_MUL;
                end
            end
            ISSUE_MUL: begin
                if (mul_cnt_next == '0) begin
                    state_next = ISSUE_IDLE;
                end else if (in_valid && !is_mul) begin
                    state_next = ISSUE_DRAIN;
                end
            end
            ISSUE_DRAIN: begin
                // held op goes out once the last multiply has left
                if (mul_cnt_next == '0) begin
                    state_next = ISSUE_IDLE;
                end
            end
            default: state_next = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state     <= ISSUE_IDLE;
            mul_cnt   <= '0;
            mul_valid <= 1'b0;
        end else begin
            state     <= state_next;
            mul_cnt   <= mul_cnt_next;
            mul_valid <= mul_issue;
        end
    end

    // operands into stage 0
    always_ff @(posedge clk) begin
        if (mul_issue) begin
            mul_a <= a_sel;
            mul_b <= b_sel;
        end
    end

    // accumulation starts from zero
    assign mul_acc = '0;

    // alu ops go straight through to the alu register
    assign alu_valid = accept && !is_mul;
    assign alu_op    = op;
    assign alu_a     = a_sel;
    assign alu_b     = b_sel;
    assign alu_word  = word_mode;

endmodule

`default_nettype wire

// ==== design/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// datapath width of the execute unit
`define EXU_XLEN 64

// number of partial-product stages in the multiply pipeline
`define EXU_MUL_STAGES 4

// multiplier bits consumed by each stage
`define EXU_MUL_SLICE (`EXU_XLEN / `EXU_MUL_STAGES)

`endif

// ==== design/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module exu_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire alu_op_pkg::alu_op_t     op,
    input  wire exu_data_pkg::xlen_t     pc,
    input  wire exu_data_pkg::xlen_t     rs1,
    input  wire exu_data_pkg::xlen_t     rs2,
    input  wire exu_data_pkg::xlen_t     csr,
    input  wire exu_data_pkg::xlen_t     imm,
    input  wire exu_data_pkg::src_sel_t  sel_a,
    input  wire exu_data_pkg::src_sel_t  sel_b,
    input  wire logic                    word_mode,
    output exu_data_pkg::xlen_t          res,
    output logic                         res_valid
);
    import alu_op_pkg::*;
    import exu_data_pkg::*;

    logic    alu_valid;
    alu_op_t alu_op;
    xlen_t   alu_a;
    xlen_t   alu_b;
    logic    alu_word;
    xlen_t   alu_res;
    logic    alu_res_valid;

    // index 0 is fed by issue, index i+1 is the output of stage i
    logic  mul_valid [0:`EXU_MUL_STAGES];
    xlen_t mul_a     [0:`EXU_MUL_STAGES];
    xlen_t mul_b     [0:`EXU_MUL_STAGES];
    xlen_t mul_acc   [0:`EXU_MUL_STAGES];

    exu_issue exu_issue_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word_mode (word_mode),
        .alu_valid (alu_valid),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_word  (alu_word),
        .mul_valid (mul_valid[0]),
        .mul_a     (mul_a[0]),
        .mul_b     (mul_b[0]),
        .mul_acc   (mul_acc[0]),
        .mul_done  (mul_valid[`EXU_MUL_STAGES])
    );

    alu_core alu_core_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .alu_valid     (alu_valid),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_word      (alu_word),
        .alu_res       (alu_res),
        .alu_res_valid (alu_res_valid)
    );

    genvar gi;
    generate
        for (gi = 0; gi < `EXU_MUL_STAGES; gi++) begin : g_mul
            mul_stage mul_stage_i (
                .clk       (clk),
                .rst       (rst),
                .flush     (flush),
                .in_valid  (mul_valid[gi]),
                .in_a      (mul_a[gi]),
                .in_b      (mul_b[gi]),
                .in_acc    (mul_acc[gi]),
                .out_valid (mul_valid[gi+1]),
                .out_a     (mul_a[gi+1]),
                .out_b     (mul_b[gi+1]),
                .out_acc   (mul_acc[gi+1])
            );
        end
    endgenerate

    // last stage accumulator is the finished product
    exu_writeback exu_writeback_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .alu_res       (alu_res),
        .alu_res_valid (alu_res_valid),
        .mul_res       (mul_acc[`EXU_MUL_STAGES]),
        .mul_res_valid (mul_valid[`EXU_MUL_STAGES]),
        .res           (res),
        .res_valid     (res_valid)
    );

endmodule

`default_nettype wire

// ==== design/exu_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module exu_writeback (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire exu_data_pkg::xlen_t  alu_res,
    input  wire logic                 alu_res_valid,
    input  wire exu_data_pkg::xlen_t  mul_res,
    input  wire logic                 mul_res_valid,
    output exu_data_pkg::xlen_t       res,
    output logic                      res_valid
);
    logic take;

    // issue ordering keeps the two sources apart in time
    assign take = !flush && (alu_res_valid || mul_res_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= take;
        end
    end

    // res holds the last result between pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (take) begin
            if (alu_res_valid) begin
                res <= alu_res;
            end else begin
                res <= mul_res;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/mul_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module mul_stage (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire logic                 in_valid,
    input  wire exu_data_pkg::xlen_t  in_a,
    input  wire exu_data_pkg::xlen_t  in_b,
    input  wire exu_data_pkg::xlen_t  in_acc,
    output logic                      out_valid,
    output exu_data_pkg::xlen_t       out_a,
    output exu_data_pkg::xlen_t       out_b,
    output exu_data_pkg::xlen_t       out_acc
);
    import exu_data_pkg::*;

    xlen_t slice;
    xlen_t partial;

    // low slice of the remaining multiplier bits
    assign slice = {{(`EXU_XLEN-`EXU_MUL_SLICE){1'b0}}, in_b[`EXU_MUL_SLICE-1:0]};

    // product wraps at the datapath width, only the low word is kept
    assign partial = in_a * slice;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // next stage sees a scaled up and b with this slice consumed
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_a   <= in_a << `EXU_MUL_SLICE;
            out_b   <= in_b >> `EXU_MUL_SLICE;
            out_acc <= in_acc + partial;
        end
    end

endmodule

`default_nettype wire

// ==== dv/exu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module exu_assert (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  flush,
    input  wire logic  in_ready,
    input  wire logic  res_valid,
    input  wire logic  mul_valid [0:`EXU_MUL_STAGES]
);
    logic mul_busy;

    // any multiply in the issue register or one of the stages
    always_comb begin
        mul_busy = 1'b0;
        for (int i = 0; i <= `EXU_MUL_STAGES; i++) begin
            mul_busy = mul_busy | mul_valid[i];
        end
    end

    a_ready_after_rst: assert property (@(posedge clk) rst |=> in_ready)
        else $error("in_ready low in the cycle after reset");

    a_no_result_after_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !res_valid)
        else $error("res_valid high in the cycle after a flush");

    // stall only exists to order results behind multiplies
    a_stall_needs_mul: assert property (
        @(posedge clk) disable iff (rst) !in_ready |-> mul_busy)
        else $error("in_ready low with no multiply in flight");

endmodule

bind exu_top exu_assert exu_assert_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .in_ready  (in_ready),
    .res_valid (res_valid),
    .mul_valid (mul_valid)
);

`default_nettype wire

// ==== dv/tb_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_params.svh"

module tb_exu;
    import alu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int          SEED     = 32'h13f2;
    localparam int          TIMEOUT  = 4000;
    localparam int          ALU_LAT  = 2;
    localparam int          MUL_LAT  = `EXU_MUL_STAGES + 2;
    localparam xlen_t       XLEN_MIN = xlen_t'(1) << (`EXU_XLEN - 1);

    logic     clk;
    logic     rst;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    alu_op_t  op;
    xlen_t    pc;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    csr;
    xlen_t    imm;
    src_sel_t sel_a;
    src_sel_t sel_b;
    logic     word_mode;
    xlen_t    res;
    logic     res_valid;

    int unsigned cyc;
    int          errors;
    int          missing;
    logic        first_ready;

    // expected results in acceptance order with the cycle they are due
    xlen_t       exp_q[$];
    int unsigned due_q[$];

    exu_top exu_top_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word_mode (word_mode),
        .res       (res),
        .res_valid (res_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cyc);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    // result monitor, sampled mid cycle where res is stable
    always @(negedge clk) begin
        if (!rst) begin
            while (due_q.size() != 0 && due_q[0] < cyc + 1) begin
                $display("result due at cycle %0d never arrived", due_q[0]);
                missing++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (res_valid) begin
                if (exp_q.size() == 0) begin
                    $display("result %h at cycle %0d with no operation pending", res, cyc + 1);
                    errors++;
                end else begin
                    if (due_q[0] != cyc + 1) begin
                        $display("result came at cycle %0d but was due at cycle %0d",
                                 cyc + 1, due_q[0]);
                        errors++;
                    end
                    check_word("res", res, exp_q[0]);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
        end
    end

    // expected value straight from the operation rules
    task automatic model_result(input alu_op_t code, input xlen_t a, input xlen_t b,
                                input logic w, output xlen_t r);
        logic [5:0]         sh;
        logic signed [31:0] lo;
        logic [127:0]       prod;
        logic               ovf;
        sh   = b[5:0];
        lo   = a[31:0];
        prod = {64'h0, a} * {64'h0, b};
        ovf  = (a == XLEN_MIN) && (b == '1);
        case (code)
            ALU_ADD:    r = a + b;
            ALU_SUB:    r = a - b;
            ALU_PASS_A: r = a;
            ALU_PASS_B: r = b;
            ALU_XOR:    r = a ^ b;
            ALU_OR:     r = a | b;
            ALU_AND:    r = a & b;
            ALU_SLL:    r = a << sh;
            ALU_SRL:    r = a >> sh;
            ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
            ALU_EQ:     r = (a == b) ? 64'd1 : 64'd0;
            ALU_GE:     r = ($signed(a) >= $signed(b)) ? 64'd1 : 64'd0;
            ALU_GEU:    r = (a >= b) ? 64'd1 : 64'd0;
            ALU_DIV:    r = (b == 0) ? '1 : ovf ? a : xlen_t'($signed(a) / $signed(b));
            ALU_DIVU:   r = (b == 0) ? '1 : a / b;
            ALU_REM:    r = (b == 0) ? a : ovf ? '0 : xlen_t'($signed(a) % $signed(b));
            ALU_REMU:   r = (b == 0) ? a : a % b;
            ALU_SRA: begin
                lo = lo >>> sh;
                r  = w ? {32'h0, lo} : xlen_t'($signed(a) >>> sh);
            end
            ALU_MUL:    r = prod[63:0];
            default:    r = '0;
        endcase
    endtask

    function automatic xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // drive one op and hold it until accepted, then queue its result
    task automatic send_op(input alu_op_t code, input xlen_t p, input xlen_t r1,
                           input xlen_t r2, input xlen_t c, input xlen_t im,
                           input src_sel_t sa, input src_sel_t sb, input logic w);
        xlen_t a;
        xlen_t b;
        xlen_t expv;
        logic  rdy;
        logic  first;
        logic  done;
        op        = code;
        pc        = p;
        rs1       = r1;
        rs2       = r2;
        csr       = c;
        imm       = im;
        sel_a     = sa;
        sel_b     = sb;
        word_mode = w;
        in_valid  = 1'b1;
        a = (sa == 2'd1) ? (w ? {32'h0, r1[31:0]} : r1) : p;
        b = (sb == 2'd1) ? r2 : (sb == 2'd2) ? c : im;
        model_result(code, a, b, w, expv);
        first = 1'b1;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            rdy = in_ready;
            if (first) begin
                first_ready = rdy;
            end
            first = 1'b0;
            @(posedge clk);
            #1;
            if (rdy) begin
                done = 1'b1;
            end
        end
        in_valid = 1'b0;
        exp_q.push_back(expv);
        due_q.push_back(cyc + ((code == ALU_MUL) ? MUL_LAT : ALU_LAT));
    endtask

    task automatic send_rand(input alu_op_t code, input src_sel_t sa, input src_sel_t sb,
                             input logic w);
        send_op(code, rand_word(), rand_word(), rand_word(), rand_word(), rand_word(),
                sa, sb, w);
    endtask

    // a from rs1 and b from rs2
    task automatic send_ab(input alu_op_t code, input xlen_t a, input xlen_t b,
                           input logic w);
        send_op(code, rand_word(), a, b, rand_word(), rand_word(), 2'd1, 2'd1, w);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic test_alu_ops();
        int code;
        int sa;
        int sb;
        for (code = 0; code <= 18; code++) begin
            for (sa = 0; sa < 4; sa++) begin
                for (sb = 0; sb < 4; sb++) begin
                    send_rand(alu_op_t'(code), src_sel_t'(sa), src_sel_t'(sb), 1'b0);
                end
            end
        end
        drain();
    endtask

    task automatic test_shifts();
        logic [5:0] amts [6];
        xlen_t      neg;
        int         i;
        amts = '{6'd0, 6'd63, 6'd1, 6'd31, 6'd32, 6'($urandom)};
        for (i = 0; i < 6; i++) begin
            send_ab(ALU_SLL, rand_word(), {rand_word()} & ~64'h3f | amts[i], 1'b0);
            send_ab(ALU_SRL, rand_word(), {rand_word()} & ~64'h3f | amts[i], 1'b0);
            send_ab(ALU_SRA, rand_word() | XLEN_MIN, {58'h0, amts[i]}, 1'b0);
            // word form with the low half negative
            neg = rand_word() | 64'h8000_0000;
            send_ab(ALU_SRA, neg, {58'h0, amts[i]}, 1'b1);
            send_ab(ALU_SRA, neg & ~64'h8000_0000, {58'h0, amts[i]}, 1'b1);
        end
        // zero extension applies to rs1 only
        send_ab(ALU_PASS_A, 64'hffff_ffff_8765_4321, rand_word(), 1'b1);
        send_ab(ALU_ADD, rand_word(), rand_word(), 1'b1);
        send_op(ALU_PASS_A, 64'hdead_beef_0000_1000, rand_word(), rand_word(), rand_word(),
                rand_word(), 2'd0, 2'd1, 1'b1);
        drain();
    endtask

    task automatic test_div();
        alu_op_t codes [4];
        int      i;
        int      j;
        codes = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        for (i = 0; i < 4; i++) begin
            send_ab(codes[i], rand_word(), '0, 1'b0);
            send_ab(codes[i], XLEN_MIN, '1, 1'b0);
            send_ab(codes[i], -64'sd7, 64'd2, 1'b0);
            for (j = 0; j < 6; j++) begin
                send_ab(codes[i], rand_word(), rand_word() >> ($urandom % 64), 1'b0);
            end
        end
        drain();
    endtask

    task automatic test_mul_stream();
        int i;
        for (i = 0; i < 20; i++) begin
            send_ab(ALU_MUL, rand_word(), rand_word(), 1'b0);
            check_flag("in_ready", first_ready, 1'b1);
        end
        drain();
    endtask

    task automatic test_order_stall();
        int i;
        for (i = 0; i < 3; i++) begin
            send_ab(ALU_MUL, rand_word(), rand_word(), 1'b0);
        end
        // held until the pipeline is empty
        send_ab(ALU_XOR, rand_word(), rand_word(), 1'b0);
        check_flag("in_ready", first_ready, 1'b0);
        drain();
    endtask

    task automatic test_flush();
        int          i;
        int unsigned flush_edge;
        for (i = 0; i < 3; i++) begin
            send_ab(ALU_MUL, rand_word(), rand_word(), 1'b0);
        end
        // op presented together with flush is dropped
        op       = ALU_MUL;
        rs1      = rand_word();
        rs2      = rand_word();
        in_valid = 1'b1;
        flush    = 1'b1;
        @(posedge clk);
        #1;
        flush_edge = cyc;
        flush      = 1'b0;
        in_valid   = 1'b0;
        while (due_q.size() != 0 && due_q[due_q.size()-1] > flush_edge) begin
            void'(exp_q.pop_back());
            void'(due_q.pop_back());
        end
        @(posedge clk);
        #1;
        // a non-multiply op right away would stall if the in-flight count survived
        send_ab(ALU_SUB, rand_word(), rand_word(), 1'b0);
        check_flag("in_ready", first_ready, 1'b1);
        drain();
    endtask

    initial begin
        void'($urandom(SEED));
        cyc         = 0;
        errors      = 0;
        missing     = 0;
        first_ready = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        op          = ALU_ADD;
        pc          = '0;
        rs1         = '0;
        rs2         = '0;
        csr         = '0;
        imm         = '0;
        sel_a       = '0;
        sel_b       = '0;
        word_mode   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_word("res", res, '0);
        check_flag("res_valid", res_valid, 1'b0);

        test_alu_ops();
        test_shifts();
        test_div();
        test_mul_stream();
        test_order_stall();
        test_flush();

        $display("errors %0d, missing results %0d", errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/alu_op_pkg.sv
design/exu_data_pkg.sv
design/exu_issue.sv
design/alu_core.sv
design/mul_stage.sv
design/exu_writeback.sv
design/exu_top.sv
dv/exu_assert.sv
dv/tb_exu.sv
